// File: src/decode_macros.svh
/*
 * Decode constants
 * MIPS-I opcode, funct and REGIMM codes, CSR map, execute credit depth
 */
`ifndef DECODE_MACROS_SVH
`define DECODE_MACROS_SVH

// Primary opcodes
`define OPC_SPECIAL 6'b000000
`define OPC_REGIMM  6'b000001
`define OPC_J       6'b000010
`define OPC_BEQ     6'b000100
`define OPC_BNE     6'b000101
`define OPC_BLEZ    6'b000110
`define OPC_BGTZ    6'b000111
`define OPC_ADDIU   6'b001001
`define OPC_SLTI    6'b001010
`define OPC_ORI     6'b001101
`define OPC_LUI     6'b001111
`define OPC_LW      6'b100011
`define OPC_SW      6'b101011

// SPECIAL funct codes
`define FN_SLL      6'b000000
`define FN_SRL      6'b000010
`define FN_SRA      6'b000011
`define FN_ADD      6'b100000
`define FN_ADDU     6'b100001
`define FN_SUB      6'b100010
`define FN_SUBU     6'b100011
`define FN_AND      6'b100100
`define FN_OR       6'b100101
`define FN_XOR      6'b100110
`define FN_NOR      6'b100111
`define FN_SLT      6'b101010
`define FN_SLTU     6'b101011

// REGIMM rt codes
`define RI_BLTZ     5'b00000
`define RI_BGEZ     5'b00001

// CSR map
`define CSR_CTRL    2'd0
`define CSR_DECODED 2'd1
`define CSR_ILLEGAL 2'd2

// Buffer slots in execute
`define EXEC_CREDITS 4

`endif

// File: src/mips_decode_pkg.sv
/*
 * MIPS decode types
 * Instruction format views, opcode and class enums, and the micro-op
 * that leaves the decode stage toward execute
 */
`default_nettype none

package mips_decode_pkg;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } i_fmt_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] index26;
    } j_fmt_t;

    // One fetched word, seen through all three formats at once
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        j_fmt_t j_fmt;
    } mips_insn_u;

    typedef enum logic [1:0] {
        I_CLASS       = 2'd0,
        J_CLASS       = 2'd1,   // Jumps, branches and REGIMM
        R_CLASS       = 2'd2,
        INVALID_CLASS = 2'd3
    } insn_class_e;

    typedef enum logic [4:0] {
        OP_ADD, OP_ADDU, OP_SUB, OP_SUBU, OP_SLT, OP_SLTU,
        OP_SLL, OP_SRL, OP_SRA,
        OP_AND, OP_OR, OP_XOR, OP_NOR,
        OP_ADDIU, OP_SLTI, OP_LW, OP_SW, OP_LUI, OP_ORI,
        OP_J, OP_BEQ, OP_BNE, OP_BGTZ, OP_BLEZ, OP_BLTZ, OP_BGEZ,
        OP_ILLEGAL
    } uop_op_e;

    typedef struct packed {
        uop_op_e     op;
        insn_class_e insn_class;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  shamt;
        logic [31:0] imm;      // Already extended
        logic [31:0] target;   // Branch or jump destination
        logic [31:0] pc;
    } decoded_uop_t;

    typedef logic [1:0] csr_addr_t;

endpackage

`default_nettype wire

// File: src/insn_decoder.sv
/*
 * Instruction decoder
 * Combinational MIPS-I subset decode of one word and its PC into a micro-op
 */
`timescale 1ns/1ns
`default_nettype none

`include "decode_macros.svh"

module insn_decoder
    import mips_decode_pkg::*;
(
    input  mips_insn_u   insn,
    input  logic [31:0]  pc,
    output decoded_uop_t uop
);

    logic [31:0] pc_plus4;
    logic [31:0] imm_sext;
    logic [31:0] imm_zext;
    logic [31:0] imm_lui;
    logic [31:0] br_target;
    logic [31:0] j_target;
    uop_op_e     fn_op;
    uop_op_e     ri_op;
    uop_op_e     opc_op;

    assign pc_plus4  = pc + 32'd4;
    assign imm_sext  = {{16{insn.i_fmt.imm16[15]}}, insn.i_fmt.imm16};
    assign imm_zext  = {16'h0000, insn.i_fmt.imm16};
    assign imm_lui   = {insn.i_fmt.imm16, 16'h0000};
    assign br_target = pc_plus4 + {imm_sext[29:0], 2'b00};
    assign j_target  = {pc_plus4[31:28], insn.j_fmt.index26, 2'b00};

    always_comb
    begin
        case (insn.r_fmt.funct)
            `FN_ADD:  fn_op = OP_ADD;
            `FN_ADDU: fn_op = OP_ADDU;
            `FN_SUB:  fn_op = OP_SUB;
            `FN_SUBU: fn_op = OP_SUBU;
            `FN_SLT:  fn_op = OP_SLT;
            `FN_SLTU: fn_op = OP_SLTU;
            `FN_SLL:  fn_op = OP_SLL;   // Also NOP
            `FN_SRL:  fn_op = OP_SRL;
            `FN_SRA:  fn_op = OP_SRA;
            `FN_AND:  fn_op = OP_AND;
            `FN_OR:   fn_op = OP_OR;
            `FN_XOR:  fn_op = OP_XOR;
            `FN_NOR:  fn_op = OP_NOR;
            default:  fn_op = OP_ILLEGAL;
        endcase
    end

    always_comb
    begin
        case (insn.i_fmt.rt)
            `RI_BLTZ: ri_op = OP_BLTZ;
            `RI_BGEZ: ri_op = OP_BGEZ;
            default:  ri_op = OP_ILLEGAL;
        endcase
    end

    always_comb
    begin
        case (insn.r_fmt.opcode)
            `OPC_SPECIAL: opc_op = fn_op;
            `OPC_REGIMM:  opc_op = ri_op;
            `OPC_J:       opc_op = OP_J;
            `OPC_BEQ:     opc_op = OP_BEQ;
            `OPC_BNE:     opc_op = OP_BNE;
            `OPC_BLEZ:    opc_op = OP_BLEZ;
            `OPC_BGTZ:    opc_op = OP_BGTZ;
            `OPC_ADDIU:   opc_op = OP_ADDIU;
            `OPC_SLTI:    opc_op = OP_SLTI;
            `OPC_ORI:     opc_op = OP_ORI;
            `OPC_LUI:     opc_op = OP_LUI;
            `OPC_LW:      opc_op = OP_LW;
            `OPC_SW:      opc_op = OP_SW;
            default:      opc_op = OP_ILLEGAL;
        endcase
    end

    // Fill fields by format; illegal words keep only the PC
    always_comb
    begin
        uop            = '0;
        uop.pc         = pc;
        uop.op         = opc_op;
        uop.insn_class = INVALID_CLASS;
        case (opc_op)
            OP_ADD, OP_ADDU, OP_SUB, OP_SUBU, OP_SLT, OP_SLTU,
            OP_SLL, OP_SRL, OP_SRA, OP_AND, OP_OR, OP_XOR, OP_NOR:
            begin
                uop.insn_class = R_CLASS;
                uop.rs         = insn.r_fmt.rs;
                uop.rt         = insn.r_fmt.rt;
                uop.rd         = insn.r_fmt.rd;
                uop.shamt      = insn.r_fmt.shamt;
            end
            OP_ADDIU, OP_SLTI, OP_LW, OP_SW, OP_ORI, OP_LUI:
            begin
                uop.insn_class = I_CLASS;
                uop.rs         = insn.i_fmt.rs;
                uop.rt         = insn.i_fmt.rt;
                if (opc_op == OP_ORI)
                    uop.imm = imm_zext;
                else if (opc_op == OP_LUI)
                    uop.imm = imm_lui;
                else
                    uop.imm = imm_sext;
            end
            OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ:
            begin
                uop.insn_class = J_CLASS;
                uop.rs         = insn.i_fmt.rs;
                uop.rt         = insn.i_fmt.rt;
                uop.imm        = imm_sext;
                uop.target     = br_target;
            end
            OP_BLTZ, OP_BGEZ:
            begin
                uop.insn_class = J_CLASS;
                uop.rs         = insn.i_fmt.rs;   // rt holds the subcode
                uop.imm        = imm_sext;
                uop.target     = br_target;
            end
            OP_J:
            begin
                uop.insn_class = J_CLASS;
                uop.target     = j_target;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: src/decode_stage.sv
/*
 * Decode pipeline stage
 * Fetch handshake, NOP squash, micro-op register and execute credit count
 */
`timescale 1ns/1ns
`default_nettype none

`include "decode_macros.svh"

module decode_stage
    import mips_decode_pkg::*;
(
    input  logic         clock,
    input  logic         rst_n,
    input  mips_insn_u   insn,
    input  logic [31:0]  pc,
    input  logic         insn_valid,
    output logic         insn_ready,
    output decoded_uop_t uop,
    output logic         uop_valid,
    input  logic         credit_return,
    input  logic         squash_nops,
    input  logic         halted,
    input  decoded_uop_t decoded_uop
);

    localparam int CREDIT_W = $clog2(`EXEC_CREDITS + 1);
    localparam logic [CREDIT_W-1:0] CREDIT_MAX = CREDIT_W'(`EXEC_CREDITS);

    logic [CREDIT_W-1:0] credits;
    logic                accept;
    logic                is_nop;
    logic                send;

    assign insn_ready = (credits != '0) && !halted;
    assign accept     = insn_valid && insn_ready;
    assign is_nop     = squash_nops && (insn == '0);   // All-zero word only
    assign send       = accept && !is_nop;

    always_ff @(posedge clock)
    begin
        if (!rst_n)
            uop_valid <= 1'b0;
        else
            uop_valid <= send;   // Single-cycle pulse per word
    end

    always_ff @(posedge clock)
    begin
        if (send)
        begin
            uop    <= decoded_uop;
            uop.pc <= pc;   // PC tagged at capture
        end
    end

    // Credit taken per micro-op sent, returned by execute
    always_ff @(posedge clock)
    begin
        if (!rst_n)
            credits <= CREDIT_MAX;
        else
        begin
            case ({send, credit_return})
                2'b10:
                    credits <= credits - 1'b1;
                2'b01:
                    if (credits != CREDIT_MAX)
                        credits <= credits + 1'b1;
                default: ;   // Send and return cancel
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/decode_csr.sv
/*
 * Decode configuration and status
 * Control bits, halt-on-illegal flag and saturating micro-op counters
 */
`timescale 1ns/1ns
`default_nettype none

`include "decode_macros.svh"

module decode_csr
    import mips_decode_pkg::*;
(
    input  logic        clock,
    input  logic        rst_n,
    input  logic        cfg_write,
    input  csr_addr_t   cfg_addr,
    input  logic [31:0] cfg_wdata,
    output logic [31:0] cfg_rdata,
    input  logic        uop_valid,
    input  uop_op_e     uop_op,
    output logic        squash_nops,
    output logic        halted
);

    logic [1:0]  ctrl;
    logic [31:0] decoded_cnt;
    logic [31:0] illegal_cnt;
    logic        ctrl_write;
    logic        illegal_out;

    assign ctrl_write  = cfg_write && (cfg_addr == `CSR_CTRL);
    assign illegal_out = uop_valid && (uop_op == OP_ILLEGAL);
    assign squash_nops = ctrl[0];

    always_ff @(posedge clock)
    begin
        if (!rst_n)
        begin
            ctrl        <= '0;
            halted      <= 1'b0;
            decoded_cnt <= '0;
            illegal_cnt <= '0;
        end
        else
        begin
            if (ctrl_write)
                ctrl <= cfg_wdata[1:0];
            if (ctrl_write)
                halted <= 1'b0;   // Software restart wins
            else if (illegal_out && ctrl[1])
                halted <= 1'b1;
            if (uop_valid && decoded_cnt != '1)
                decoded_cnt <= decoded_cnt + 1'b1;
            if (illegal_out && illegal_cnt != '1)
                illegal_cnt <= illegal_cnt + 1'b1;
        end
    end

    always_comb
    begin
        case (cfg_addr)
            `CSR_CTRL:    cfg_rdata = {30'd0, ctrl};
            `CSR_DECODED: cfg_rdata = decoded_cnt;
            `CSR_ILLEGAL: cfg_rdata = illegal_cnt;
            default:      cfg_rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: src/decode_top.sv
/*
 * Decode stage top level
 * Joins the pipeline stage, the instruction decoder and the CSR block
 */
`timescale 1ns/1ns
`default_nettype none

module decode_top
    import mips_decode_pkg::*;
(
    input  logic         clock,
    input  logic         rst_n,
    input  mips_insn_u   insn,
    input  logic [31:0]  pc,
    input  logic         insn_valid,
    output logic         insn_ready,
    output decoded_uop_t uop,
    output logic         uop_valid,
    input  logic         credit_return,
    input  logic         cfg_write,
    input  csr_addr_t    cfg_addr,
    input  logic [31:0]  cfg_wdata,
    output logic [31:0]  cfg_rdata
);

    decoded_uop_t dec_uop;
    logic         squash_nops;
    logic         halted;

    insn_decoder i_decoder (
        .insn (insn),
        .pc   (pc),
        .uop  (dec_uop)
    );

    decode_stage i_stage (
        .clock         (clock),
        .rst_n         (rst_n),
        .insn          (insn),
        .pc            (pc),
        .insn_valid    (insn_valid),
        .insn_ready    (insn_ready),
        .uop           (uop),
        .uop_valid     (uop_valid),
        .credit_return (credit_return),
        .squash_nops   (squash_nops),
        .halted        (halted),
        .decoded_uop   (dec_uop)
    );

    decode_csr i_csr (
        .clock       (clock),
        .rst_n       (rst_n),
        .cfg_write   (cfg_write),
        .cfg_addr    (cfg_addr),
        .cfg_wdata   (cfg_wdata),
        .cfg_rdata   (cfg_rdata),
        .uop_valid   (uop_valid),
        .uop_op      (uop.op),
        .squash_nops (squash_nops),
        .halted      (halted)
    );

endmodule

`default_nettype wire

// File: bench/tb_decode_top.sv
/*
 * Decode stage testbench
 * Replays instruction vectors, acts as execute for the credit return,
 * and checks micro-ops, flow control, NOP squash, halt and counters
 */
`timescale 1ns/1ns
`default_nettype none

module tb_decode_top
    import mips_decode_pkg::*;
();

    localparam csr_addr_t CSR_CTRL_A    = 2'd0;
    localparam csr_addr_t CSR_DECODED_A = 2'd1;
    localparam csr_addr_t CSR_ILLEGAL_A = 2'd2;
    localparam int        CREDITS       = 4;
    localparam int        TIMEOUT       = 200;   // Cycles per wait loop

    logic         clock;
    logic         rst_n;
    mips_insn_u   insn;
    logic [31:0]  pc;
    logic         insn_valid;
    logic         insn_ready;
    decoded_uop_t uop;
    logic         uop_valid;
    logic         credit_return;
    logic         cfg_write;
    csr_addr_t    cfg_addr;
    logic [31:0]  cfg_wdata;
    logic [31:0]  cfg_rdata;

    logic [31:0]  vec_word[$];
    decoded_uop_t vec_uop[$];
    decoded_uop_t expected_q[$];
    logic [31:0]  lfsr_state;
    int           outstanding;   // Micro-ops held by execute
    int           grant_count;   // Credits to hand back regardless of returns_on
    logic         returns_on;
    int           rx_count;
    int           rx_illegal;

    decode_top i_dut (.*);

    always #20 clock = ~clock;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "run aborted");
    endtask

    task automatic report_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        abort_run($sformatf("FAIL %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic check_uop(input decoded_uop_t got, input decoded_uop_t exp);
        if (got.op !== exp.op)
            report_value("uop.op", 32'(got.op), 32'(exp.op));
        if (got.insn_class !== exp.insn_class)
            report_value("uop.insn_class", 32'(got.insn_class), 32'(exp.insn_class));
        if (got.rs !== exp.rs)
            report_value("uop.rs", 32'(got.rs), 32'(exp.rs));
        if (got.rt !== exp.rt)
            report_value("uop.rt", 32'(got.rt), 32'(exp.rt));
        if (got.rd !== exp.rd)
            report_value("uop.rd", 32'(got.rd), 32'(exp.rd));
        if (got.shamt !== exp.shamt)
            report_value("uop.shamt", 32'(got.shamt), 32'(exp.shamt));
        if (got.imm !== exp.imm)
            report_value("uop.imm", got.imm, exp.imm);
        if (got.target !== exp.target)
            report_value("uop.target", got.target, exp.target);
        if (got.pc !== exp.pc)
            report_value("uop.pc", got.pc, exp.pc);
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp)
            report_value(name, got, exp);
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
            report_value(name, 32'(got), 32'(exp));
    endtask

    function automatic logic random_bit();
        lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
        return lfsr_state[0];
    endfunction

    // One cycle from the execute side: take a micro-op, maybe return a credit
    task automatic tick();
        decoded_uop_t exp;
        @(negedge clock);
        if (uop_valid === 1'b1)
        begin
            if (expected_q.size() == 0)
                abort_run("A micro-op arrived when none was expected");
            else
            begin
                exp = expected_q.pop_front();
                check_uop(uop, exp);
                rx_count++;
                if (exp.op == OP_ILLEGAL)
                    rx_illegal++;
                outstanding++;
            end
        end
        credit_return = 1'b0;
        if (outstanding > 0 && grant_count > 0)
        begin
            credit_return = 1'b1;
            grant_count--;
        end
        else if (outstanding > 0 && returns_on && random_bit())
            credit_return = 1'b1;
        if (credit_return)
            outstanding--;
    endtask

    task automatic send_vector(input int idx, input logic stall_ok, input logic squashed);
        int waited;
        if (stall_ok && random_bit())
        begin
            insn_valid = 1'b0;
            tick();
        end
        insn       = vec_word[idx];
        pc         = vec_uop[idx].pc;
        insn_valid = 1'b1;
        waited     = 0;
        while (insn_ready !== 1'b1)
        begin
            tick();
            waited++;
            if (waited > TIMEOUT)
                abort_run("Timeout while waiting for insn_ready");
        end
        if (!squashed)
            expected_q.push_back(vec_uop[idx]);
        tick();   // Taken on the rising edge inside this cycle
        insn_valid = 1'b0;
        if (expected_q.size() != 0)
            abort_run("A micro-op did not leave one cycle after its word was accepted");
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (expected_q.size() != 0 || outstanding != 0)
        begin
            tick();
            waited++;
            if (waited > TIMEOUT)
                abort_run("Timeout while waiting for expected micro-ops and credits");
        end
    endtask

    task automatic read_csr(input csr_addr_t addr, input logic [31:0] exp, input string name);
        cfg_addr = addr;
        tick();
        check_word(name, cfg_rdata, exp);
    endtask

    task automatic write_ctrl(input logic [31:0] value);
        cfg_write = 1'b1;
        cfg_addr  = CSR_CTRL_A;
        cfg_wdata = value;
        tick();
        cfg_write = 1'b0;
    endtask

    task automatic check_counters();
        read_csr(CSR_DECODED_A, 32'(rx_count), "cfg_rdata[DECODED]");
        read_csr(CSR_ILLEGAL_A, 32'(rx_illegal), "cfg_rdata[ILLEGAL]");
    endtask

    task automatic load_vectors();
        int           fd;
        int           n;
        string        line;
        logic [31:0]  f_pc, f_word, f_op, f_cls, f_rs, f_rt, f_rd, f_sh, f_imm, f_tgt;
        decoded_uop_t e;
        fd = $fopen("bench/decode_input.txt", "r");
        if (fd == 0)
            abort_run("Cannot open the vector file bench/decode_input.txt");
        while (!$feof(fd))
        begin
            n = $fgets(line, fd);
            if (n > 0 && $sscanf(line, "%h %h %h %h %h %h %h %h %h %h", f_pc, f_word, f_op,
                                 f_cls, f_rs, f_rt, f_rd, f_sh, f_imm, f_tgt) == 10)
            begin
                e            = '0;
                e.op         = uop_op_e'(f_op[4:0]);
                e.insn_class = insn_class_e'(f_cls[1:0]);
                e.rs         = f_rs[4:0];
                e.rt         = f_rt[4:0];
                e.rd         = f_rd[4:0];
                e.shamt      = f_sh[4:0];
                e.imm        = f_imm;
                e.target     = f_tgt;
                e.pc         = f_pc;
                vec_word.push_back(f_word);
                vec_uop.push_back(e);
            end
        end
        $fclose(fd);
    endtask

    function automatic int find_vector(input logic want_nop);
        for (int i = 0; i < vec_uop.size(); i++)
            if (want_nop ? (vec_word[i] == 32'h0) : (vec_uop[i].op == OP_ILLEGAL))
                return i;
        return -1;
    endfunction

    initial
    begin
        int base;
        int nop_idx;
        int bad_idx;
        clock         = 1'b0;
        rst_n         = 1'b0;
        insn          = '0;
        pc            = '0;
        insn_valid    = 1'b0;
        credit_return = 1'b0;
        cfg_write     = 1'b0;
        cfg_addr      = CSR_CTRL_A;
        cfg_wdata     = '0;
        lfsr_state    = 32'h14bf;
        outstanding   = 0;
        grant_count   = 0;
        returns_on    = 1'b1;
        rx_count      = 0;
        rx_illegal    = 0;
        load_vectors();
        nop_idx = find_vector(1'b1);
        bad_idx = find_vector(1'b0);
        if (nop_idx < 0 || bad_idx < 0 || vec_uop.size() <= CREDITS)
            abort_run("The vector file lacks a NOP, an illegal word or enough lines");
        insn       = vec_word[0];   // Offered while in reset
        pc         = vec_uop[0].pc;
        insn_valid = 1'b1;
        repeat (3) tick();
        check_flag("uop_valid", uop_valid, 1'b0);
        insn_valid = 1'b0;
        rst_n      = 1'b1;

        tick();
        check_flag("uop_valid", uop_valid, 1'b0);
        check_flag("insn_ready", insn_ready, 1'b1);
        read_csr(CSR_CTRL_A, 32'h0, "cfg_rdata[CTRL]");
        check_counters();

        for (int i = 0; i < vec_uop.size(); i++)
            send_vector(i, 1'b1, 1'b0);
        drain();
        check_counters();

        // No returns, so the stage stops after the credit depth
        returns_on = 1'b0;
        base       = rx_count;
        for (int i = 0; i < CREDITS; i++)
            send_vector(i, 1'b0, 1'b0);
        insn       = vec_word[CREDITS];
        pc         = vec_uop[CREDITS].pc;
        insn_valid = 1'b1;
        repeat (6)
        begin
            tick();
            check_flag("insn_ready", insn_ready, 1'b0);
        end
        check_word("micro-ops received", 32'(rx_count - base), 32'(CREDITS));
        grant_count = 1;
        send_vector(CREDITS, 1'b0, 1'b0);
        repeat (4)
        begin
            tick();
            check_flag("insn_ready", insn_ready, 1'b0);
        end
        check_word("micro-ops received", 32'(rx_count - base), 32'(CREDITS + 1));
        returns_on = 1'b1;
        drain();

        write_ctrl(32'h1);
        send_vector(nop_idx, 1'b0, 1'b1);
        repeat (4) tick();
        check_counters();

        write_ctrl(32'h2);
        read_csr(CSR_CTRL_A, 32'h2, "cfg_rdata[CTRL]");
        send_vector(bad_idx, 1'b0, 1'b0);
        drain();
        tick();
        check_flag("insn_ready", insn_ready, 1'b0);
        write_ctrl(32'h0);
        check_flag("insn_ready", insn_ready, 1'b1);
        for (int i = 0; i < CREDITS; i++)
            send_vector(i, 1'b1, 1'b0);
        drain();
        check_counters();

        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: decode_top.f
+incdir+src
src/mips_decode_pkg.sv
src/insn_decoder.sv
src/decode_stage.sv
src/decode_csr.sv
src/decode_top.sv
bench/tb_decode_top.sv

// File: run_sim.sh
#!/bin/sh
# Build the decode stage testbench with Verilator, run it, and grade the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing -Wno-fatal --top-module tb_decode_top -f decode_top.f \
    -o tb_decode_top > build.log 2>&1 || { cat build.log; echo "Build error"; exit 1; }
./obj_dir/tb_decode_top > sim.log 2>&1
cat sim.log
grep -q "Regression passed" sim.log && exit 0 || exit 1

// File: bench/decode_input.txt
# pc word op class rs rt rd shamt imm target, all hex, one instruction per line
# op is the micro-op enum code (1A illegal), class is 0=I 1=J 2=R 3=invalid
00400000 00221820 00 2 01 02 03 00 00000000 00000000
00400004 00853021 01 2 04 05 06 00 00000000 00000000
00400008 00E84822 02 2 07 08 09 00 00000000 00000000
0040000C 014B6023 03 2 0A 0B 0C 00 00000000 00000000
00400010 01AE782A 04 2 0D 0E 0F 00 00000000 00000000
00400014 0211902B 05 2 10 11 12 00 00000000 00000000
00400018 00031100 06 2 00 03 02 04 00000000 00000000
0040001C 00062FC2 07 2 00 06 05 1F 00000000 00000000
00400020 00083843 08 2 00 08 07 01 00000000 00000000
00400024 0274A824 09 2 13 14 15 00 00000000 00000000
00400028 02D7C025 0A 2 16 17 18 00 00000000 00000000
0040002C 033AD826 0B 2 19 1A 1B 00 00000000 00000000
00400030 039DF027 0C 2 1C 1D 1E 00 00000000 00000000
00400034 00000000 06 2 00 00 00 00 00000000 00000000
00400038 00221801 1A 3 00 00 00 00 00000000 00000000
0040003C 27A8FFF0 0D 0 1D 08 00 00 FFFFFFF0 00000000
00400040 28897FFF 0E 0 04 09 00 00 00007FFF 00000000
00400044 8FAA0010 0F 0 1D 0A 00 00 00000010 00000000
00400048 AFABFFFC 10 0 1D 0B 00 00 FFFFFFFC 00000000
0040004C 3C011234 11 0 00 01 00 00 12340000 00000000
00400050 34218765 12 0 01 01 00 00 00008765 00000000
00400100 10220003 14 1 01 02 00 00 00000003 00400110
00400200 1464FFFF 15 1 03 04 00 00 FFFFFFFF 00400200
00400300 18A00010 17 1 05 00 00 00 00000010 00400344
00400400 1CC0FFF0 16 1 06 00 00 00 FFFFFFF0 004003C4
00400500 04E00020 18 1 07 00 00 00 00000020 00400584
00400600 05018000 19 1 08 00 00 00 FFFF8000 003E0604
1FFFFFFC 08100040 13 1 00 00 00 00 00000000 20400100
00400060 04220004 1A 3 00 00 00 00 00000000 00000000
00400064 FFFFFFFF 1A 3 00 00 00 00 00000000 00000000
